// File: include/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// word size of registers and buses
`define DATA_WIDTH 32

`define IMEM_WORDS 256
`define DMEM_WORDS 256

// APB byte address map
`define APB_ADDR_WIDTH 12
`define IMEM_BASE   12'h000
`define DMEM_BASE   12'h400
`define CTRL_ADDR   12'h800
`define STATUS_ADDR 12'h804
`define PC_ADDR     12'h808

`endif

// File: verilog/cpuPkg.sv
package cpuPkg;

    // standard MIPS primary opcodes
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcodeE;

    // funct field of R-type words
    typedef enum logic [5:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_SLT = 6'h2a
    } functE;

    // operation class handed from the decoder to the ALU
    typedef enum logic [1:0] {
        ALU_ADD   = 2'b00,
        ALU_SUB   = 2'b01,
        ALU_FUNCT = 2'b10,
        ALU_IMM   = 2'b11
    } aluOpE;

    typedef struct packed {
        opcodeE     opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        functE      funct;
    } rFieldsS;

    typedef struct packed {
        opcodeE      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFieldsS;

    typedef struct packed {
        opcodeE      opcode;
        logic [25:0] target26;
    } jFieldsS;

    // one instruction word, three decodings
    typedef union packed {
        rFieldsS rFields;
        iFieldsS iFields;
        jFieldsS jFields;
    } instrU;

endpackage

// File: verilog/memBus.sv
`include "cpu_cfg.svh"

interface memBus;
    localparam int ImemBits = $clog2(`IMEM_WORDS);
    localparam int DmemBits = $clog2(`DMEM_WORDS);

    // word indices, not byte addresses
    logic [ImemBits-1:0]    imemAddr;
    logic [`DATA_WIDTH-1:0] instr;
    logic [DmemBits-1:0]    dataAddr;
    logic [`DATA_WIDTH-1:0] dataWdata;
    logic                   dataWe;
    logic [`DATA_WIDTH-1:0] dataRdata;

    modport core (output imemAddr, dataAddr, dataWdata, dataWe,
                  input instr, dataRdata);

    modport mem (input imemAddr, dataAddr, dataWdata, dataWe,
                 output instr, dataRdata);
endinterface

// File: verilog/opcodeControl.sv
module opcodeControl import cpuPkg::*; (
    input  opcodeE opcode,
    input  functE  funct,
    output logic   regDst,
    output logic   jump,
    output logic   jumpAndLink,
    output logic   jumpRegister,
    output logic   branch,
    output logic   branchNe,
    output logic   memRead,
    output logic   memToReg,
    output logic   memWrite,
    output logic   aluSrc,
    output logic   regWrite,
    output logic   shiftOp,
    output logic   loadUpperImm,
    output aluOpE  aluOp
);
    logic isR;
    logic isJ;
    logic isJal;
    logic isJr;
    logic isBeq;
    logic isBne;
    logic isAddi;
    logic isAndi;
    logic isOri;
    logic isXori;
    logic isLw;
    logic isSw;
    logic isLui;
    logic isSll;
    logic isSrl;

    // one-hot instruction flags
    always_comb begin
        isR    = (opcode == OP_RTYPE);
        isJ    = (opcode == OP_J);
        isJal  = (opcode == OP_JAL);
        isBeq  = (opcode == OP_BEQ);
        isBne  = (opcode == OP_BNE);
        isAddi = (opcode == OP_ADDI);
        isAndi = (opcode == OP_ANDI);
        isOri  = (opcode == OP_ORI);
        isXori = (opcode == OP_XORI);
        isLw   = (opcode == OP_LW);
        isSw   = (opcode == OP_SW);
        isLui  = (opcode == OP_LUI);
        // funct only means something for R-type
        isJr   = isR && (funct == FN_JR);
        isSll  = isR && (funct == FN_SLL);
        isSrl  = isR && (funct == FN_SRL);
    end

    always_comb begin
        case (opcode)
            OP_RTYPE: aluOp = ALU_FUNCT;
            OP_BEQ, OP_BNE: aluOp = ALU_SUB;
            OP_ANDI, OP_ORI, OP_XORI: aluOp = ALU_IMM;
            default: aluOp = ALU_ADD;
        endcase
    end

    assign regDst       = isR;
    assign jump         = isJ || isJal;
    assign jumpAndLink  = isJal;
    assign jumpRegister = isJr;
    assign branch       = isBeq;
    assign branchNe     = isBne;
    assign memRead      = isLw;
    assign memToReg     = isLw;
    assign memWrite     = isSw;
    assign aluSrc       = isLw || isSw || isAddi || isAndi || isOri || isXori;
    // listed positively so unknown opcodes never write
    assign regWrite     = (isR && !isJr) || isJal || isAddi || isAndi || isOri ||
                          isXori || isLw || isLui;
    assign shiftOp      = isSll || isSrl;
    assign loadUpperImm = isLui;
endmodule

// File: verilog/alu.sv
`include "cpu_cfg.svh"

module alu import cpuPkg::*; (
    input  aluOpE                  aluOp,
    input  functE                  funct,
    input  opcodeE                 opcode,
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    input  logic [4:0]             shamt,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   zero
);
    logic lessThan;

    assign lessThan = ($signed(a) < $signed(b));

    always_comb begin
        case (aluOp)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_FUNCT: begin
                case (funct)
                    FN_SUB: result = a - b;
                    FN_AND: result = a & b;
                    FN_OR:  result = a | b;
                    FN_XOR: result = a ^ b;
                    FN_SLT: result = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
                    // shifts act on rt
                    FN_SLL: result = b << shamt;
                    FN_SRL: result = b >> shamt;
                    default: result = a + b;
                endcase
            end
            ALU_IMM: begin
                // logical immediates, picked by opcode
                case (opcode)
                    OP_ANDI: result = a & b;
                    OP_ORI:  result = a | b;
                    OP_XORI: result = a ^ b;
                    default: result = a + b;
                endcase
            end
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);
endmodule

// File: verilog/regFile.sv
`include "cpu_cfg.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [4:0]             readAddrA,
    input  logic [4:0]             readAddrB,
    input  logic [4:0]             writeAddr,
    input  logic [`DATA_WIDTH-1:0] writeData,
    input  logic                   writeEn,
    output logic [`DATA_WIDTH-1:0] readDataA,
    output logic [`DATA_WIDTH-1:0] readDataB
);
    logic [`DATA_WIDTH-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != 5'd0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // r0 is hardwired
    assign readDataA = (readAddrA == 5'd0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == 5'd0) ? '0 : regs[readAddrB];
endmodule

// File: verilog/cpuCore.sv
`include "cpu_cfg.svh"

module cpuCore import cpuPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   run,
    memBus.core                    mem,
    output logic                   halted,
    output logic [`DATA_WIDTH-1:0] pc
);
    localparam int ImemBits = $clog2(`IMEM_WORDS);
    localparam int DmemBits = $clog2(`DMEM_WORDS);

    instrU instr;

    logic  regDst;
    logic  jump;
    logic  jumpAndLink;
    logic  jumpRegister;
    logic  branch;
    logic  branchNe;
    logic  memRead;
    logic  memToReg;
    logic  memWrite;
    logic  aluSrc;
    logic  regWrite;
    logic  shiftOp;
    logic  loadUpperImm;
    aluOpE aluOp;

    logic [`DATA_WIDTH-1:0] rsData;
    logic [`DATA_WIDTH-1:0] rtData;
    logic [`DATA_WIDTH-1:0] signExt;
    logic [`DATA_WIDTH-1:0] immExt;
    logic [`DATA_WIDTH-1:0] aluB;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic [`DATA_WIDTH-1:0] writeData;
    logic [`DATA_WIDTH-1:0] pcPlus1;
    logic [`DATA_WIDTH-1:0] jumpTarget;
    logic [`DATA_WIDTH-1:0] pcNext;
    logic [4:0]             writeAddr;
    logic [4:0]             shamt;
    logic                   zero;
    logic                   active;
    logic                   branchTaken;
    logic                   selfJump;

    assign instr  = mem.instr;
    assign active = run && !halted;

    opcodeControl i_opcodeControl (
        .opcode      (instr.rFields.opcode),
        .funct       (instr.rFields.funct),
        .regDst      (regDst),
        .jump        (jump),
        .jumpAndLink (jumpAndLink),
        .jumpRegister(jumpRegister),
        .branch      (branch),
        .branchNe    (branchNe),
        .memRead     (memRead),
        .memToReg    (memToReg),
        .memWrite    (memWrite),
        .aluSrc      (aluSrc),
        .regWrite    (regWrite),
        .shiftOp     (shiftOp),
        .loadUpperImm(loadUpperImm),
        .aluOp       (aluOp)
    );

    // jal links into r31
    assign writeAddr = jumpAndLink ? 5'd31 :
                       regDst      ? instr.rFields.rd : instr.iFields.rt;

    regFile i_regFile (
        .clk      (clk),
        .rstN     (rstN),
        .readAddrA(instr.rFields.rs),
        .readAddrB(instr.rFields.rt),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .writeEn  (regWrite && active),
        .readDataA(rsData),
        .readDataB(rtData)
    );

    // logical immediates are zero-extended
    assign signExt = {{(`DATA_WIDTH-16){instr.iFields.imm16[15]}}, instr.iFields.imm16};
    assign immExt  = (aluOp == ALU_IMM) ? {{(`DATA_WIDTH-16){1'b0}}, instr.iFields.imm16}
                                        : signExt;
    assign aluB    = aluSrc ? immExt : rtData;
    assign shamt   = shiftOp ? instr.rFields.shamt : 5'd0;

    alu i_alu (
        .aluOp (aluOp),
        .funct (instr.rFields.funct),
        .opcode(instr.rFields.opcode),
        .a     (rsData),
        .b     (aluB),
        .shamt (shamt),
        .result(aluResult),
        .zero  (zero)
    );

    always_comb begin
        if (jumpAndLink) begin
            writeData = pcPlus1;
        end else if (loadUpperImm) begin
            writeData = {instr.iFields.imm16, 16'h0000};
        end else if (memToReg) begin
            writeData = mem.dataRdata;
        end else begin
            writeData = aluResult;
        end
    end

    // data memory is word addressed as well
    assign mem.imemAddr  = pc[ImemBits-1:0];
    assign mem.dataAddr  = (memRead || memWrite) ? aluResult[DmemBits-1:0] : '0;
    assign mem.dataWdata = rtData;
    assign mem.dataWe    = memWrite && active;

    assign pcPlus1     = pc + 1'b1;
    assign jumpTarget  = {{(`DATA_WIDTH-26){1'b0}}, instr.jFields.target26};
    assign branchTaken = (branch && zero) || (branchNe && !zero);
    assign selfJump    = jump && !jumpAndLink && (jumpTarget == pc);

    always_comb begin
        if (jumpRegister) begin
            pcNext = rsData;
        end else if (jump) begin
            pcNext = jumpTarget;
        end else if (branchTaken) begin
            pcNext = pcPlus1 + signExt;
        end else begin
            pcNext = pcPlus1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (!run) begin
            // stopped core waits at address 0
            pc     <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            pc <= pcNext;
            if (selfJump) begin
                halted <= 1'b1;
            end
        end
    end
endmodule

// File: verilog/hostMemory.sv
`include "cpu_cfg.svh"

module hostMemory (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0] paddr,
    input  logic [`DATA_WIDTH-1:0]     pwdata,
    output logic [`DATA_WIDTH-1:0]     prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  logic                       halted,
    input  logic [`DATA_WIDTH-1:0]     pc,
    memBus.mem                         mem,
    output logic                       run
);
    localparam int ImemBits = $clog2(`IMEM_WORDS);
    localparam int DmemBits = $clog2(`DMEM_WORDS);

    logic [`DATA_WIDTH-1:0]     imem [`IMEM_WORDS];
    logic [`DATA_WIDTH-1:0]     dmem [`DMEM_WORDS];
    logic [`APB_ADDR_WIDTH-1:0] imemOffset;
    logic [`APB_ADDR_WIDTH-1:0] dmemOffset;
    logic [DmemBits-1:0]        dmemWaddr;
    logic [`DATA_WIDTH-1:0]     dmemWdata;
    logic [`DATA_WIDTH-1:0]     readValue;
    logic inImem;
    logic inDmem;
    logic isCtrl;
    logic isStatus;
    logic isPc;
    logic writeErr;
    logic readWait;
    logic writeDone;
    logic hostDmemWe;

    assign imemOffset = paddr - `IMEM_BASE;
    assign dmemOffset = paddr - `DMEM_BASE;
    assign inImem     = (paddr >= `IMEM_BASE) && (paddr < `IMEM_BASE + 4 * `IMEM_WORDS);
    assign inDmem     = (paddr >= `DMEM_BASE) && (paddr < `DMEM_BASE + 4 * `DMEM_WORDS);
    assign isCtrl     = (paddr == `CTRL_ADDR);
    assign isStatus   = (paddr == `STATUS_ADDR);
    assign isPc       = (paddr == `PC_ADDR);

    // memories are locked while the core runs, status and pc are read-only
    assign writeErr = !(inImem || inDmem || isCtrl) || ((inImem || inDmem) && run);

    always_comb begin
        if (inImem) readValue = imem[imemOffset[ImemBits+1:2]];
        else if (inDmem) readValue = dmem[dmemOffset[DmemBits+1:2]];
        else if (isCtrl) readValue = {{(`DATA_WIDTH-1){1'b0}}, run};
        else if (isStatus) readValue = {{(`DATA_WIDTH-1){1'b0}}, halted};
        else readValue = pc;
    end

    // reads wait one cycle, writes answer in the first access cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pready   <= 1'b0;
            pslverr  <= 1'b0;
            readWait <= 1'b0;
        end else begin
            pready   <= 1'b0;
            pslverr  <= 1'b0;
            readWait <= 1'b0;
            if (psel && !penable) begin
                pready   <= pwrite;
                pslverr  <= pwrite && writeErr;
                readWait <= !pwrite;
            end else if (readWait) begin
                pready  <= 1'b1;
                pslverr <= !(inImem || inDmem || isCtrl || isStatus || isPc);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (readWait) begin
            prdata <= readValue;
        end
    end

    assign writeDone = psel && penable && pready && pwrite && !pslverr;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            run <= 1'b0;
        end else if (writeDone && isCtrl) begin
            run <= pwdata[0];
        end
    end

    // host and core never write data memory in the same cycle
    assign hostDmemWe = writeDone && inDmem;
    assign dmemWaddr  = hostDmemWe ? dmemOffset[DmemBits+1:2] : mem.dataAddr;
    assign dmemWdata  = hostDmemWe ? pwdata : mem.dataWdata;

    always_ff @(posedge clk) begin
        if (hostDmemWe || mem.dataWe) begin
            dmem[dmemWaddr] <= dmemWdata;
        end
        if (writeDone && inImem) begin
            imem[imemOffset[ImemBits+1:2]] <= pwdata;
        end
    end

    assign mem.instr     = imem[mem.imemAddr];
    assign mem.dataRdata = dmem[mem.dataAddr];
endmodule

// File: verilog/mipsSystem.sv
`include "cpu_cfg.svh"

module mipsSystem (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0] paddr,
    input  logic [`DATA_WIDTH-1:0]     pwdata,
    output logic [`DATA_WIDTH-1:0]     prdata,
    output logic                       pready,
    output logic                       pslverr
);
    logic                   run;
    logic                   halted;
    logic [`DATA_WIDTH-1:0] pc;

    // fetch and data path between core and arrays
    memBus memIf ();

    cpuCore i_cpuCore (
        .clk   (clk),
        .rstN  (rstN),
        .run   (run),
        .mem   (memIf.core),
        .halted(halted),
        .pc    (pc)
    );

    hostMemory i_hostMemory (
        .clk    (clk),
        .rstN   (rstN),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr),
        .halted (halted),
        .pc     (pc),
        .mem    (memIf.mem),
        .run    (run)
    );
endmodule

// File: test/mipsSystem_props.sv
`include "cpu_cfg.svh"

module mipsSystem_props (
    input logic                       clk,
    input logic                       rstN,
    input logic                       psel,
    input logic                       penable,
    input logic                       pwrite,
    input logic [`APB_ADDR_WIDTH-1:0] paddr,
    input logic                       pready,
    input logic                       halted,
    input logic [`DATA_WIDTH-1:0]     pc,
    input logic                       run
);
    timeunit 1ns;
    timeprecision 1ps;

    // address and direction hold through the access phase
    apbStable: assert property (@(posedge clk) disable iff (!rstN)
        psel && penable |-> $stable(paddr) && $stable(pwrite))
        else $error("paddr or pwrite changed during an APB access");

    readyPulse: assert property (@(posedge clk) disable iff (!rstN)
        pready |=> !pready)
        else $error("pready stayed high for more than one cycle");

    haltHold: assert property (@(posedge clk) disable iff (!rstN)
        halted && run |=> $stable(pc))
        else $error("pc moved while the core was halted");

    runAfterReset: assert property (@(posedge clk) !rstN |=> !run)
        else $error("run was set right after reset");
endmodule

bind hostMemory mipsSystem_props i_props (.*);

// File: test/mipsSystem_tb.sv
`include "cpu_cfg.svh"

module mipsSystem_tb import cpuPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TimeoutCycles = 4000;

    logic                       clk;
    logic                       rstN;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [`DATA_WIDTH-1:0]     pwdata;
    logic [`DATA_WIDTH-1:0]     prdata;
    logic                       pready;
    logic                       pslverr;

    int          mismatchCount = 0;
    int          otherCount = 0;
    int          cycleCount = 0;
    logic [31:0] lfsrState = 32'h80a5_3f61;
    logic [31:0] prog [$];
    logic [31:0] expectedWords [$];

    mipsSystem i_mipsSystem (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
            $display("Regression failed");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] takeBits(int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [31:0] encR(functE fn, logic [4:0] rd, logic [4:0] rs,
                                         logic [4:0] rt, logic [4:0] sh);
        instrU w;
        w.rFields = '{opcode: OP_RTYPE, rs: rs, rt: rt, rd: rd, shamt: sh, funct: fn};
        return w;
    endfunction

    function automatic logic [31:0] encI(opcodeE op, logic [4:0] rt, logic [4:0] rs,
                                         logic [15:0] imm);
        instrU w;
        w.iFields = '{opcode: op, rs: rs, rt: rt, imm16: imm};
        return w;
    endfunction

    function automatic logic [31:0] encJ(opcodeE op, logic [25:0] target);
        instrU w;
        w.jFields = '{opcode: op, target26: target};
        return w;
    endfunction

    function automatic logic [`APB_ADDR_WIDTH-1:0] dataAddr(int word);
        return `DMEM_BASE + 12'(4 * word);
    endfunction

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            mismatchCount++;
        end
    endtask

    task automatic apbWrite(input logic [`APB_ADDR_WIDTH-1:0] addr,
                            input logic [31:0] data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        do @(negedge clk); while (pready !== 1'b1);
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apbRead(input logic [`APB_ADDR_WIDTH-1:0] addr,
                           output logic [31:0] data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        do @(negedge clk); while (pready !== 1'b1);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic writeWord(input logic [`APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        logic err;
        apbWrite(addr, data, err);
        if (err !== 1'b0) begin
            $display("slave error on a write to address %h that should have succeeded", addr);
            otherCount++;
        end
    endtask

    task automatic readWord(input logic [`APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        logic err;
        apbRead(addr, data, err);
        if (err !== 1'b0) begin
            $display("slave error on a read of address %h that should have succeeded", addr);
            otherCount++;
        end
    endtask

    task automatic loadProgram();
        foreach (prog[i]) begin
            writeWord(`IMEM_BASE + 12'(4 * i), prog[i]);
        end
    endtask

    // start, wait for the self-jump, capture pc, stop
    task automatic runProgram(output logic [31:0] haltPc);
        logic [31:0] status;
        writeWord(`CTRL_ADDR, 32'd1);
        do readWord(`STATUS_ADDR, status); while (status[0] !== 1'b1);
        readWord(`PC_ADDR, haltPc);
        writeWord(`CTRL_ADDR, 32'd0);
    endtask

    task automatic addAluStep(input logic [31:0] word, input logic [31:0] result);
        prog.push_back(word);
        prog.push_back(encI(OP_SW, 3, 0, 16'(expectedWords.size())));
        expectedWords.push_back(result);
    endtask

    task automatic testApbAccess();
        logic [31:0] pattern [4];
        logic [31:0] value;
        logic        err;
        for (int i = 0; i < 4; i++) begin
            pattern[i] = takeBits(32);
            writeWord(dataAddr(100 + i), pattern[i]);
        end
        for (int i = 0; i < 4; i++) begin
            readWord(dataAddr(100 + i), value);
            checkEq(value, pattern[i], $sformatf("data memory readback %0d", i));
        end
        readWord(`CTRL_ADDR, value);
        checkEq(value, 32'd0, "CTRL after reset");
        readWord(`PC_ADDR, value);
        checkEq(value, 32'd0, "PC while stopped");
        // a lone self-jump parks the core at 0 with run set
        prog = {encJ(OP_J, 26'd0)};
        loadProgram();
        writeWord(`CTRL_ADDR, 32'd1);
        readWord(`CTRL_ADDR, value);
        checkEq(value, 32'd1, "CTRL with run set");
        apbWrite(dataAddr(100), ~pattern[0], err);
        checkEq(err, 1'b1, "pslverr on data write while running");
        apbWrite(`IMEM_BASE, 32'h0, err);
        checkEq(err, 1'b1, "pslverr on instruction write while running");
        readWord(dataAddr(100), value);
        checkEq(value, pattern[0], "data word after refused write");
        readWord(`IMEM_BASE, value);
        checkEq(value, encJ(OP_J, 26'd0), "instruction word after refused write");
        readWord(`PC_ADDR, value);
        checkEq(value, 32'd0, "PC of halted self-jump");
        apbWrite(`STATUS_ADDR, 32'h0, err);
        checkEq(err, 1'b1, "pslverr on STATUS write");
        readWord(`STATUS_ADDR, value);
        checkEq(value, 32'd1, "STATUS after refused write");
        writeWord(`CTRL_ADDR, 32'd0);
        apbWrite(12'h80c, 32'h1, err);
        checkEq(err, 1'b1, "pslverr on unmapped write");
        apbRead(12'hc00, value, err);
        checkEq(err, 1'b1, "pslverr on unmapped read");
        readWord(`CTRL_ADDR, value);
        checkEq(value, 32'd0, "CTRL after unmapped write");
    endtask

    task automatic testAluOps();
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] immS;
        logic [31:0] immZ;
        logic [31:0] value;
        logic [31:0] haltPc;
        logic [15:0] imm;
        logic [4:0]  sh;
        opA  = takeBits(32);
        opB  = takeBits(32);
        imm  = 16'(takeBits(16));
        sh   = 5'(takeBits(5));
        immS = {{16{imm[15]}}, imm};
        immZ = {16'h0000, imm};
        expectedWords = {};
        prog = {encI(OP_LUI, 1, 0, opA[31:16]), encI(OP_ORI, 1, 1, opA[15:0]),
                encI(OP_LUI, 2, 0, opB[31:16]), encI(OP_ORI, 2, 2, opB[15:0])};
        addAluStep(encR(FN_ADD, 3, 1, 2, 0), opA + opB);
        addAluStep(encR(FN_SUB, 3, 1, 2, 0), opA - opB);
        addAluStep(encR(FN_AND, 3, 1, 2, 0), opA & opB);
        addAluStep(encR(FN_OR, 3, 1, 2, 0), opA | opB);
        addAluStep(encR(FN_XOR, 3, 1, 2, 0), opA ^ opB);
        addAluStep(encR(FN_SLT, 3, 1, 2, 0), {31'd0, $signed(opA) < $signed(opB)});
        addAluStep(encR(FN_SLT, 3, 2, 1, 0), {31'd0, $signed(opB) < $signed(opA)});
        addAluStep(encR(FN_SLL, 3, 0, 2, sh), opB << sh);
        addAluStep(encR(FN_SRL, 3, 0, 2, sh), opB >> sh);
        addAluStep(encI(OP_ADDI, 3, 1, imm), opA + immS);
        addAluStep(encI(OP_ANDI, 3, 1, imm), opA & immZ);
        addAluStep(encI(OP_ORI, 3, 1, imm), opA | immZ);
        addAluStep(encI(OP_XORI, 3, 1, imm), opA ^ immZ);
        addAluStep(encI(OP_LUI, 3, 0, imm), {imm, 16'h0000});
        // write to r0, then store r0
        prog.push_back(encI(OP_ADDI, 0, 1, imm));
        prog.push_back(encI(OP_SW, 0, 0, 16'(expectedWords.size())));
        expectedWords.push_back(32'd0);
        prog.push_back(encJ(OP_J, 26'(prog.size())));
        loadProgram();
        runProgram(haltPc);
        checkEq(haltPc, 32'(prog.size() - 1), "PC at ALU program self-jump");
        foreach (expectedWords[i]) begin
            readWord(dataAddr(i), value);
            checkEq(value, expectedWords[i], $sformatf("ALU result word %0d", i));
        end
    endtask

    task automatic testLoadStore();
        logic [31:0] source [4];
        logic [31:0] value;
        logic [31:0] haltPc;
        prog = {encI(OP_ADDI, 5, 0, 16'd32)};
        for (int i = 0; i < 4; i++) begin
            source[i] = takeBits(32);
            writeWord(dataAddr(32 + i), source[i]);
            prog.push_back(encI(OP_LW, 4, 5, 16'(i)));
            prog.push_back(encI(OP_ADDI, 4, 4, 16'hfff9));
            prog.push_back(encI(OP_SW, 4, 5, 16'(8 + i)));
        end
        prog.push_back(encJ(OP_J, 26'(prog.size())));
        loadProgram();
        runProgram(haltPc);
        checkEq(haltPc, 32'(prog.size() - 1), "PC at copy program self-jump");
        for (int i = 0; i < 4; i++) begin
            readWord(dataAddr(40 + i), value);
            checkEq(value, source[i] - 32'd7, $sformatf("copied word %0d", i));
            readWord(dataAddr(32 + i), value);
            checkEq(value, source[i], $sformatf("source word %0d", i));
        end
    endtask

    task automatic testBranches();
        logic [31:0] value;
        logic [31:0] haltPc;
        int          count;
        int          sum;
        count = takeBits(4) + 3;
        writeWord(dataAddr(48), 32'hdead_beef);
        writeWord(dataAddr(49), 32'hdead_beef);
        prog = {encI(OP_ADDI, 6, 0, 16'(count)), encI(OP_ADDI, 7, 0, 16'd0),
                encR(FN_ADD, 7, 7, 6, 0), encI(OP_ADDI, 6, 6, 16'hffff),
                encI(OP_BNE, 0, 6, 16'hfffd), encI(OP_BEQ, 0, 6, 16'h0001),
                encI(OP_ADDI, 7, 7, 16'd1000), encI(OP_BEQ, 0, 7, 16'h0001),
                encI(OP_SW, 6, 0, 16'd48), encI(OP_SW, 7, 0, 16'd49), encJ(OP_J, 26'd10)};
        // sum of the counter values on the way down to zero
        sum = 0;
        do begin
            sum += count;
            count--;
        end while (count != 0);
        loadProgram();
        runProgram(haltPc);
        checkEq(haltPc, 32'd10, "PC at loop program self-jump");
        readWord(dataAddr(48), value);
        checkEq(value, 32'(count), "final loop counter");
        readWord(dataAddr(49), value);
        checkEq(value, 32'(sum), "loop sum");
    endtask

    task automatic testJumps();
        logic [31:0] value;
        logic [31:0] haltPc;
        prog = {encI(OP_ADDI, 8, 0, 16'd5), encJ(OP_JAL, 26'd4), encI(OP_SW, 31, 0, 16'd50),
                encJ(OP_J, 26'd3), encI(OP_ADDI, 8, 8, 16'd7), encI(OP_SW, 8, 0, 16'd51),
                encR(FN_JR, 0, 31, 0, 0)};
        loadProgram();
        runProgram(haltPc);
        checkEq(haltPc, 32'd3, "PC at self-jump");
        readWord(dataAddr(50), value);
        // jal sits at word 1
        checkEq(value, 32'd1 + 32'd1, "jal link value");
        readWord(dataAddr(51), value);
        checkEq(value, 32'd12, "subroutine result");
        readWord(`STATUS_ADDR, value);
        checkEq(value, 32'd0, "STATUS after run cleared");
        prog = {encI(OP_ADDI, 9, 0, 16'd77), encI(OP_SW, 9, 0, 16'd52), encJ(OP_J, 26'd2)};
        loadProgram();
        runProgram(haltPc);
        checkEq(haltPc, 32'd2, "PC at second self-jump");
        readWord(dataAddr(52), value);
        checkEq(value, 32'd77, "second program result");
    endtask

    initial begin
        rstN    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        testApbAccess();
        testAluOps();
        testLoadStore();
        testBranches();
        testJumps();
        $display("errors: %0d value mismatches, %0d other failures", mismatchCount, otherCount);
        if (mismatchCount + otherCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end
endmodule

// File: mipsSystem.f
+incdir+include
verilog/cpuPkg.sv
verilog/memBus.sv
verilog/opcodeControl.sv
verilog/alu.sv
verilog/regFile.sv
verilog/cpuCore.sv
verilog/hostMemory.sv
verilog/mipsSystem.sv
test/mipsSystem_props.sv
test/mipsSystem_tb.sv

// File: Bender.yml
package:
  name: mips_system

export_include_dirs:
  - include

sources:
  - verilog/cpuPkg.sv
  - verilog/memBus.sv
  - verilog/opcodeControl.sv
  - verilog/alu.sv
  - verilog/regFile.sv
  - verilog/cpuCore.sv
  - verilog/hostMemory.sv
  - verilog/mipsSystem.sv
  - target: test
    files:
      - test/mipsSystem_props.sv
      - test/mipsSystem_tb.sv
